//--- alert_pkg.sv
// Shared constants and types for the reduced alert handler.
// Imported by every module of the design with a wildcard import
// in the module header.

package alert_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Alert classes, each with its own accumulator and escalation FSM
  parameter int unsigned N_CLASSES = 4;

  // Escalation severities, one per phase
  parameter int unsigned N_ESC_SEV = 4;

  // Width of a class index
  parameter int unsigned CLASS_DW = 2;

  //////////////////////////////////////////////////////////////////////
  // Counter widths
  //////////////////////////////////////////////////////////////////////

  // Accumulation count and its threshold
  parameter int unsigned ACCU_CNT_DW = 8;

  // Cycles with a pending interrupt, and the timeout limit
  parameter int unsigned TIMEOUT_DW = 12;

  // Phase length count
  parameter int unsigned PHASE_DW = 12;

  // Escalation state encoding width
  parameter int unsigned ESC_STATE_DW = 3;

  //////////////////////////////////////////////////////////////////////
  // Escalation states
  //////////////////////////////////////////////////////////////////////

  // Idle until a trigger, then four timed phases and a terminal state
  // that is only left through a class clear
  typedef enum logic [ESC_STATE_DW-1:0] {
    StIdle     = 3'd0,
    StPhase0   = 3'd1,
    StPhase1   = 3'd2,
    StPhase2   = 3'd3,
    StPhase3   = 3'd4,
    StTerminal = 3'd5
  } esc_state_e;

  // Index of the last phase, used when leaving StPhase3
  parameter int unsigned LAST_PHASE = N_ESC_SEV - 1;

  // Phase p drives severities 0..p, so the request is a prefix mask
  // of p+1 ones
  typedef logic [N_ESC_SEV-1:0] esc_req_t;

endpackage

//--- alert_handler_class.sv
// Alert classification for the alert handler.
// Maps each enabled alert to its class, keeps the sticky cause bits
// and the sticky per-class interrupts. Instantiated once by the top.

`timescale 1ns/1ps

module alert_handler_class
  import alert_pkg::*;
#(
  parameter int unsigned NAlerts = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [NAlerts-1:0]           alert_i,
  input  logic [NAlerts-1:0]           alert_en_i,
  input  logic [NAlerts*CLASS_DW-1:0]  alert_class_i,
  input  logic [N_CLASSES-1:0]         class_en_i,
  input  logic [N_CLASSES-1:0]         irq_clr_i,
  input  logic                         cause_clr_i,
  output logic [N_CLASSES-1:0]         class_trig_o,
  output logic [NAlerts-1:0]           cause_o,
  output logic [N_CLASSES-1:0]         irq_o
);

  // Alerts that are enabled and land in an enabled class
  logic [NAlerts-1:0] alert_hit;

  //////////////////////////////////////////////////////////////////////
  // Classification
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_classify
    logic [CLASS_DW-1:0] cls;
    class_trig_o = '0;
    alert_hit    = '0;
    for (int j = 0; j < NAlerts; j++) begin
      cls = alert_class_i[j*CLASS_DW +: CLASS_DW];
      alert_hit[j] = alert_i[j] & alert_en_i[j] & class_en_i[cls];
      class_trig_o[cls] = class_trig_o[cls] | alert_hit[j];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sticky cause bits
  //////////////////////////////////////////////////////////////////////

  // Clear wins over a new hit in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cause_o <= '0;
    end else if (cause_clr_i) begin
      cause_o <= '0;
    end else begin
      cause_o <= cause_o | alert_hit;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sticky interrupts
  //////////////////////////////////////////////////////////////////////

  // One bit per class, cleared by its own irq_clr_i
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      irq_o <= '0;
    end else begin
      irq_o <= (irq_o | class_trig_o) & ~irq_clr_i;
    end
  end

endmodule

//--- alert_handler_accu.sv
// Per-class alert accumulator.
// Counts class triggers, saturating at the maximum, and raises a
// trigger when an alert arrives with the count at or above threshold.

`timescale 1ns/1ps

module alert_handler_accu
  import alert_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   class_trig_i,
  input  logic                   clr_i,
  input  logic [ACCU_CNT_DW-1:0] thresh_i,
  output logic [ACCU_CNT_DW-1:0] accu_cnt_o,
  output logic                   accu_trig_o
);

  logic cnt_sat;

  // Counter stops at all ones
  assign cnt_sat = &accu_cnt_o;

  //////////////////////////////////////////////////////////////////////
  // Accumulation counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      accu_cnt_o <= '0;
    end else if (clr_i) begin
      accu_cnt_o <= '0;
    end else if (class_trig_i && !cnt_sat) begin
      accu_cnt_o <= accu_cnt_o + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Threshold trigger
  //////////////////////////////////////////////////////////////////////

  // Compared against the count before this alert is added, so with
  // threshold N the (N+1)-th alert is the first to trigger
  assign accu_trig_o = class_trig_i && (accu_cnt_o >= thresh_i);

endmodule

//--- alert_handler_timeout.sv
// Per-class interrupt timeout counter.
// Counts cycles with a pending interrupt on an enabled class and
// signals a timeout once the limit is reached. Limit 0 disables it.

`timescale 1ns/1ps

module alert_handler_timeout
  import alert_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  irq_i,
  input  logic                  en_i,
  input  logic                  clr_i,
  input  logic [TIMEOUT_DW-1:0] timeout_cyc_i,
  output logic                  timeout_trig_o
);

  logic [TIMEOUT_DW-1:0] cnt_q;
  logic                  at_limit;

  assign at_limit = (cnt_q >= timeout_cyc_i);

  //////////////////////////////////////////////////////////////////////
  // Pending cycle counter
  //////////////////////////////////////////////////////////////////////

  // Restarts from zero whenever the interrupt is not pending,
  // holds once the limit is reached
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (clr_i || !irq_i) begin
      cnt_q <= '0;
    end else if (en_i && !at_limit) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Timeout trigger
  assign timeout_trig_o = irq_i && en_i && (timeout_cyc_i != '0) && at_limit;

endmodule

//--- alert_handler_esc_fsm.sv
// Per-class escalation state machine.
// Starts escalation on an accumulation or timeout trigger, steps
// through four timed phases and then holds in the terminal state
// until the class is cleared.

`timescale 1ns/1ps

module alert_handler_esc_fsm
  import alert_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 en_i,
  input  logic                 clr_i,
  input  logic                 accu_trig_i,
  input  logic                 timeout_trig_i,
  input  logic [PHASE_DW-1:0]  phase_cyc_i,
  output esc_state_e           esc_state_o,
  output logic [N_ESC_SEV-1:0] esc_req_o
);

  esc_state_e          state_d, state_q;
  logic [PHASE_DW-1:0] phase_cnt_d, phase_cnt_q;
  logic                esc_start;
  logic                phase_done;

  //////////////////////////////////////////////////////////////////////
  // Trigger combination
  //////////////////////////////////////////////////////////////////////

  // Either source starts escalation on an enabled class
  assign esc_start = en_i && (accu_trig_i || timeout_trig_i);

  // Last cycle of the current phase, phase_cyc+1 cycles in total
  assign phase_done = (phase_cnt_q >= phase_cyc_i);

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    phase_cnt_d = phase_cnt_q;

    unique case (state_q)
      StIdle: begin
        phase_cnt_d = '0;
        if (esc_start) begin
          state_d = StPhase0;
        end
      end

      StPhase0, StPhase1, StPhase2, StPhase3: begin
        if (phase_done) begin
          phase_cnt_d = '0;
          case (state_q)
            StPhase0: state_d = StPhase1;
            StPhase1: state_d = StPhase2;
            StPhase2: state_d = StPhase3;
            default:  state_d = StTerminal;
          endcase
        end else begin
          phase_cnt_d = phase_cnt_q + 1'b1;
        end
      end

      // Held until the class is cleared
      StTerminal: begin
        phase_cnt_d = '0;
      end

      default: begin
        state_d     = StIdle;
        phase_cnt_d = '0;
      end
    endcase

    // Class clear returns to idle from any state
    if (clr_i) begin
      state_d     = StIdle;
      phase_cnt_d = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State and phase counter registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= StIdle;
      phase_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      phase_cnt_q <= phase_cnt_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Severity requests
  //////////////////////////////////////////////////////////////////////

  // Decoded from the registered state, one more severity per phase
  always_comb begin
    unique case (state_q)
      StPhase0:             esc_req_o = 4'b0001;
      StPhase1:             esc_req_o = 4'b0011;
      StPhase2:             esc_req_o = 4'b0111;
      StPhase3, StTerminal: esc_req_o = 4'b1111;
      default:              esc_req_o = 4'b0000;
    endcase
  end

  assign esc_state_o = state_q;

endmodule

//--- alert_handler.sv
// Reduced alert handler top level.
// Classifies alert pulses into four classes, accumulates them, runs
// one escalation FSM per class and ORs the per-class requests into
// the escalation severity outputs.

`timescale 1ns/1ps

module alert_handler
  import alert_pkg::*;
#(
  parameter int unsigned NAlerts = 8
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  // Alert sources and their configuration
  input  logic [NAlerts-1:0]              alert_i,
  input  logic [NAlerts-1:0]              alert_en_i,
  input  logic [NAlerts*CLASS_DW-1:0]     alert_class_i,
  // Class configuration and clears
  input  logic [N_CLASSES-1:0]            class_en_i,
  input  logic [N_CLASSES-1:0]            class_clr_i,
  input  logic [N_CLASSES-1:0]            irq_clr_i,
  input  logic [N_CLASSES*ACCU_CNT_DW-1:0] accu_thresh_i,
  input  logic [N_CLASSES*TIMEOUT_DW-1:0] timeout_cyc_i,
  input  logic [N_CLASSES*PHASE_DW-1:0]   phase_cyc_i,
  // Status and interrupts
  output logic [NAlerts-1:0]              cause_o,
  output logic [N_CLASSES-1:0]            irq_o,
  output logic [N_CLASSES*ACCU_CNT_DW-1:0] accu_cnt_o,
  output esc_state_e [N_CLASSES-1:0]      esc_state_o,
  // Escalation severities
  output logic [N_ESC_SEV-1:0]            esc_o
);

  logic [N_CLASSES-1:0] class_trig;
  logic                 cause_clr;

  logic [N_CLASSES-1:0][N_ESC_SEV-1:0] class_esc_req;

  //////////////////////////////////////////////////////////////////////
  // Classification
  //////////////////////////////////////////////////////////////////////

  // Any class clear wipes all cause bits
  assign cause_clr = |class_clr_i;

  alert_handler_class #(
    .NAlerts(NAlerts)
  ) u_class (
    .clk_i,
    .rst_i,
    .alert_i,
    .alert_en_i,
    .alert_class_i,
    .class_en_i,
    .irq_clr_i,
    .cause_clr_i   ( cause_clr  ),
    .class_trig_o  ( class_trig ),
    .cause_o,
    .irq_o
  );

  //////////////////////////////////////////////////////////////////////
  // Per-class accumulation, timeout and escalation
  //////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < N_CLASSES; k++) begin : gen_classes
    logic accu_trig;
    logic timeout_trig;

    alert_handler_accu u_accu (
      .clk_i,
      .rst_i,
      .class_trig_i  ( class_trig[k]                                 ),
      .clr_i         ( class_clr_i[k]                                ),
      .thresh_i      ( accu_thresh_i[k*ACCU_CNT_DW +: ACCU_CNT_DW]   ),
      .accu_cnt_o    ( accu_cnt_o[k*ACCU_CNT_DW +: ACCU_CNT_DW]      ),
      .accu_trig_o   ( accu_trig                                     )
    );

    // Timeout runs while the class interrupt is pending
    alert_handler_timeout u_timeout (
      .clk_i,
      .rst_i,
      .irq_i          ( irq_o[k]                                   ),
      .en_i           ( class_en_i[k]                              ),
      .clr_i          ( class_clr_i[k]                             ),
      .timeout_cyc_i  ( timeout_cyc_i[k*TIMEOUT_DW +: TIMEOUT_DW]  ),
      .timeout_trig_o ( timeout_trig                               )
    );

    alert_handler_esc_fsm u_esc_fsm (
      .clk_i,
      .rst_i,
      .en_i           ( class_en_i[k]                          ),
      .clr_i          ( class_clr_i[k]                         ),
      .accu_trig_i    ( accu_trig                              ),
      .timeout_trig_i ( timeout_trig                           ),
      .phase_cyc_i    ( phase_cyc_i[k*PHASE_DW +: PHASE_DW]    ),
      .esc_state_o    ( esc_state_o[k]                         ),
      .esc_req_o      ( class_esc_req[k]                       )
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Severity combining
  //////////////////////////////////////////////////////////////////////

  // Each severity is raised by any class requesting it
  always_comb begin
    esc_o = '0;
    for (int c = 0; c < N_CLASSES; c++) begin
      esc_o = esc_o | class_esc_req[c];
    end
  end

endmodule

//--- tb_clk_gen.sv
// Testbench clock and reset source.
// 4 ns clock, reset held high for the first 4 rising edges.

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Released just after the fourth edge, in step with the stimulus
  initial begin
    rst_o = 1'b1;
    repeat (4) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

endmodule

//--- alert_handler_assertions.sv
// Concurrent checks on the alert handler top level.
// Bound to every alert_handler instance, reports through $error only.

`timescale 1ns/1ps

module alert_handler_assertions
  import alert_pkg::*;
(
  input logic                       clk_i,
  input logic                       rst_i,
  input logic [N_CLASSES-1:0]       class_en_i,
  input logic [N_CLASSES-1:0]       irq_clr_i,
  input logic [N_CLASSES-1:0]       irq_i,
  input esc_state_e [N_CLASSES-1:0] esc_state_i,
  input logic [N_ESC_SEV-1:0]       esc_i
);

  // Severities come in order, so esc_o is always a run of low ones
  assert property (@(posedge clk_i) disable iff (rst_i)
    (esc_i & (esc_i + 1'b1)) == '0)
    else $error("esc_o is not a prefix of ones: %b", esc_i);

  for (genvar k = 0; k < N_CLASSES; k++) begin : gen_class_checks
    // A disabled class stays idle
    assert property (@(posedge clk_i) disable iff (rst_i)
      (!class_en_i[k] && esc_state_i[k] == StIdle) |=> (esc_state_i[k] == StIdle))
      else $error("class %0d left idle while disabled", k);

    assert property (@(posedge clk_i) disable iff (rst_i)
      irq_clr_i[k] |=> !irq_i[k])
      else $error("irq of class %0d still high after its clear", k);
  end

endmodule

bind alert_handler alert_handler_assertions u_assertions (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .class_en_i  ( class_en_i  ),
  .irq_clr_i   ( irq_clr_i   ),
  .irq_i       ( irq_o       ),
  .esc_state_i ( esc_state_o ),
  .esc_i       ( esc_o       )
);

//--- alert_handler_tb.sv
// Table-driven testbench for the reduced alert handler.
// Applies a list of steps to the DUT, runs a cycle-level reference
// model next to it and compares all status outputs after each step.

`timescale 1ns/1ps

module alert_handler_tb
  import alert_pkg::*;
();

  localparam int unsigned NA = 8;
  // Alert j goes to class j mod 4
  localparam logic [NA*CLASS_DW-1:0] CLASS_MAP = 16'he4e4;
  localparam int unsigned PHASE_LEN = 2;

  typedef struct {
    string name;
    int    rnd;
    int    c_en;
    int    thr;
    int    tout;
    int    alert;
    int    cclr;
    int    iclr;
    int    cyc;
    int    exp_esc;
  } step_t;

  logic clk;
  logic rst;
  logic [NA-1:0] alert_i, alert_en_i, cause_o;
  logic [NA*CLASS_DW-1:0] alert_class_i;
  logic [N_CLASSES-1:0] class_en_i, class_clr_i, irq_clr_i, irq_o;
  logic [N_CLASSES*ACCU_CNT_DW-1:0] accu_thresh_i, accu_cnt_o;
  logic [N_CLASSES*TIMEOUT_DW-1:0] timeout_cyc_i;
  logic [N_CLASSES*PHASE_DW-1:0] phase_cyc_i;
  esc_state_e [N_CLASSES-1:0] esc_state_o;
  logic [N_ESC_SEV-1:0] esc_o;

  step_t steps[$];
  int cycle_cnt = 0;
  int cycle_limit = 0;

  // Reference model state
  logic [NA-1:0] m_cause;
  logic [N_CLASSES-1:0] m_irq;
  logic [ACCU_CNT_DW-1:0] m_cnt [N_CLASSES];
  logic [TIMEOUT_DW-1:0] m_tcnt [N_CLASSES];
  logic [PHASE_DW-1:0] m_pcnt [N_CLASSES];
  esc_state_e m_state [N_CLASSES];

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_o(rst));

  alert_handler #(.NAlerts(NA)) dut_i (
    .clk_i(clk), .rst_i(rst), .alert_i, .alert_en_i, .alert_class_i, .class_en_i,
    .class_clr_i, .irq_clr_i, .accu_thresh_i, .timeout_cyc_i, .phase_cyc_i,
    .cause_o, .irq_o, .accu_cnt_o, .esc_state_o, .esc_o
  );

  task automatic add_step(input string name, input int rnd, c_en, thr, tout, alert,
                          cclr, iclr, cyc, exp_esc);
    step_t st;
    st = '{name, rnd, c_en, thr, tout, alert, cclr, iclr, cyc, exp_esc};
    steps.push_back(st);
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      $display("MISMATCH %s %s: expected %0h, actual %0h", test, what, exp_v, act_v);
      $display("SOME TESTS FAILED");
      $fatal(1, "Check failed in step %s", test);
    end
  endtask

  // Phase p requests severities 0..p
  function automatic logic [N_ESC_SEV-1:0] sev_mask(input esc_state_e st);
    case (st)
      StPhase0:             return 4'b0001;
      StPhase1:             return 4'b0011;
      StPhase2:             return 4'b0111;
      StPhase3, StTerminal: return 4'b1111;
      default:              return 4'b0000;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model, one call per rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic model_step();
    logic [NA-1:0] hit;
    logic [N_CLASSES-1:0] trig;
    logic [CLASS_DW-1:0] cls;
    logic [TIMEOUT_DW-1:0] lim;
    logic accu_t;
    logic tout_t;
    hit = '0;
    trig = '0;
    for (int j = 0; j < NA; j++) begin
      cls = alert_class_i[j*CLASS_DW +: CLASS_DW];
      hit[j] = alert_i[j] & alert_en_i[j] & class_en_i[cls];
      trig[cls] = trig[cls] | hit[j];
    end
    for (int c = 0; c < N_CLASSES; c++) begin
      lim = timeout_cyc_i[c*TIMEOUT_DW +: TIMEOUT_DW];
      accu_t = trig[c] && (m_cnt[c] >= accu_thresh_i[c*ACCU_CNT_DW +: ACCU_CNT_DW]);
      tout_t = m_irq[c] && class_en_i[c] && (lim != 0) && (m_tcnt[c] >= lim);
      if (class_clr_i[c]) begin
        m_state[c] = StIdle;
        m_pcnt[c] = '0;
      end else if (m_state[c] == StIdle) begin
        if (class_en_i[c] && (accu_t || tout_t)) m_state[c] = StPhase0;
      end else if (m_state[c] != StTerminal) begin
        if (m_pcnt[c] >= phase_cyc_i[c*PHASE_DW +: PHASE_DW]) begin
          m_pcnt[c] = '0;
          case (m_state[c])
            StPhase0: m_state[c] = StPhase1;
            StPhase1: m_state[c] = StPhase2;
            StPhase2: m_state[c] = StPhase3;
            default:  m_state[c] = StTerminal;
          endcase
        end else begin
          m_pcnt[c] = m_pcnt[c] + 1'b1;
        end
      end
      if (class_clr_i[c]) m_cnt[c] = '0;
      else if (trig[c] && m_cnt[c] != '1) m_cnt[c] = m_cnt[c] + 1'b1;
      // Pending time follows the irq as it was before this edge
      if (class_clr_i[c] || !m_irq[c]) m_tcnt[c] = '0;
      else if (class_en_i[c] && m_tcnt[c] < lim) m_tcnt[c] = m_tcnt[c] + 1'b1;
    end
    m_irq = (m_irq | trig) & ~irq_clr_i;
    m_cause = (|class_clr_i) ? '0 : (m_cause | hit);
  endtask

  // Run limit, counted from the end of reset
  always @(posedge clk) begin
    if (!rst) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
        $display("Run did not finish within %0d cycles", cycle_limit);
        $display("SOME TESTS FAILED");
        $fatal(1, "Timeout");
      end
    end
  end

  initial begin
    void'($urandom(37));
    alert_i = '0;
    alert_en_i = '0;
    alert_class_i = '0;
    class_en_i = '0;
    class_clr_i = '0;
    irq_clr_i = '0;
    accu_thresh_i = '0;
    timeout_cyc_i = '0;
    phase_cyc_i = '0;
    m_cause = '0;
    m_irq = '0;
    for (int c = 0; c < N_CLASSES; c++) begin
      m_cnt[c] = '0;
      m_tcnt[c] = '0;
      m_pcnt[c] = '0;
      m_state[c] = StIdle;
    end

    //       name           rnd c_en thr  tout alert cclr iclr cyc esc
    add_step("cls_rand0",    1, 'hf, 255, 0,   'h00, 0,   0,   1,  'h0);
    add_step("cls_rand1",    1, 'h5, 255, 0,   'h00, 0,   0,   1,  'h0);
    add_step("cls_off",      1, 'h0, 255, 0,   'h00, 0,   0,   1,  'h0);
    add_step("cls_rand2",    1, 'hf, 255, 0,   'h00, 0,   0,   1,  'h0);
    add_step("irq_clr_c0",   0, 'hf, 255, 0,   'h00, 0,   'h1, 1,  'h0);
    add_step("class_clr",    0, 'hf, 255, 0,   'h00, 'hf, 'he, 1,  'h0);
    add_step("accu_1",       0, 'hf, 2,   0,   'h01, 0,   0,   1,  'h0);
    add_step("accu_2",       0, 'hf, 2,   0,   'h01, 0,   0,   1,  'h0);
    add_step("accu_3",       0, 'hf, 2,   0,   'h01, 0,   0,   1,  'h1);
    add_step("phase0_end",   0, 'hf, 2,   0,   'h00, 0,   0,   2,  'h1);
    add_step("phase1",       0, 'hf, 2,   0,   'h00, 0,   0,   1,  'h3);
    add_step("phase2",       0, 'hf, 2,   0,   'h00, 0,   0,   3,  'h7);
    add_step("phase3",       0, 'hf, 2,   0,   'h00, 0,   0,   3,  'hf);
    add_step("terminal",     0, 'hf, 2,   0,   'h00, 0,   0,   8,  'hf);
    add_step("accu_clr",     0, 'hf, 2,   0,   'h00, 'h1, 'h1, 1,  'h0);
    add_step("tout_alert",   0, 'hf, 255, 5,   'h02, 0,   0,   1,  'h0);
    add_step("tout_wait",    0, 'hf, 255, 5,   'h00, 0,   0,   5,  'h0);
    add_step("tout_esc",     0, 'hf, 255, 5,   'h00, 0,   0,   1,  'h1);
    add_step("tout_clr",     0, 'hf, 255, 5,   'h00, 'h2, 'h2, 1,  'h0);
    add_step("tout0_wait",   0, 'hf, 255, 0,   'h04, 0,   0,   20, 'h0);
    add_step("tout0_clr",    0, 'hf, 255, 0,   'h00, 'h4, 'h4, 1,  'h0);
    add_step("comb_c2",      0, 'hf, 0,   0,   'h04, 0,   0,   1,  'h1);
    add_step("comb_wait",    0, 'hf, 0,   0,   'h00, 0,   0,   5,  'h3);
    add_step("comb_c3",      0, 'hf, 0,   0,   'h08, 0,   0,   1,  'h7);
    add_step("comb_c2_clr",  0, 'hf, 0,   0,   'h00, 'h4, 'h4, 1,  'h1);
    add_step("comb_c3_run",  0, 'hf, 0,   0,   'h00, 0,   0,   3,  'h3);
    add_step("comb_end",     0, 'hf, 0,   0,   'h00, 'hf, 'hf, 1,  'h0);
    add_step("dis_c3",       0, 'h7, 0,   0,   'h08, 0,   0,   3,  'h0);
    foreach (steps[s]) cycle_limit += 2 * steps[s].cyc;

    @(negedge rst);
    foreach (steps[s]) begin
      // Configuration levels and one-cycle pulses
      alert_en_i = '1;
      alert_class_i = CLASS_MAP;
      alert_i = steps[s].alert[NA-1:0];
      if (steps[s].rnd != 0) begin
        alert_i = NA'($urandom());
        alert_en_i = NA'($urandom());
        alert_class_i = (NA*CLASS_DW)'($urandom());
      end
      class_en_i = steps[s].c_en[N_CLASSES-1:0];
      class_clr_i = steps[s].cclr[N_CLASSES-1:0];
      irq_clr_i = steps[s].iclr[N_CLASSES-1:0];
      accu_thresh_i = {N_CLASSES{steps[s].thr[ACCU_CNT_DW-1:0]}};
      timeout_cyc_i = {N_CLASSES{steps[s].tout[TIMEOUT_DW-1:0]}};
      phase_cyc_i = {N_CLASSES{PHASE_DW'(PHASE_LEN)}};
      for (int k = 0; k < steps[s].cyc; k++) begin
        @(posedge clk);
        model_step();
        #1;
        alert_i = '0;
        class_clr_i = '0;
        irq_clr_i = '0;
      end
      check_value(steps[s].name, "cause_o", m_cause, cause_o);
      check_value(steps[s].name, "irq_o", m_irq, irq_o);
      for (int c = 0; c < N_CLASSES; c++) begin
        check_value(steps[s].name, $sformatf("accu_cnt_o[%0d]", c), m_cnt[c],
                    accu_cnt_o[c*ACCU_CNT_DW +: ACCU_CNT_DW]);
        check_value(steps[s].name, $sformatf("esc_state_o[%0d]", c), m_state[c],
                    esc_state_o[c]);
      end
      check_value(steps[s].name, "esc_o model",
                  sev_mask(m_state[0]) | sev_mask(m_state[1]) |
                  sev_mask(m_state[2]) | sev_mask(m_state[3]), esc_o);
      check_value(steps[s].name, "esc_o table", steps[s].exp_esc, esc_o);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- alert_handler.f
alert_pkg.sv
alert_handler_class.sv
alert_handler_accu.sv
alert_handler_timeout.sv
alert_handler_esc_fsm.sv
alert_handler.sv
tb_clk_gen.sv
alert_handler_assertions.sv
alert_handler_tb.sv

//--- Bender.yml
package:
  name: alert_handler

sources:
  - alert_pkg.sv
  - alert_handler_class.sv
  - alert_handler_accu.sv
  - alert_handler_timeout.sv
  - alert_handler_esc_fsm.sv
  - alert_handler.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - alert_handler_assertions.sv
      - alert_handler_tb.sv
